//--- hdl/irq_pkg.sv
package irq_pkg;

    // Field widths.
    localparam int xlen         = 32;
    localparam int be_w         = xlen / 8;
    localparam int mtime_w      = 64;
    localparam int cause_w      = 4;
    localparam int mtvec_mode_w = 2;
    localparam int mtvec_base_w = xlen - mtvec_mode_w;

    // Register map, byte offsets.
    localparam logic [xlen-1:0] addr_mstatus     = 32'h0000_0000;
    localparam logic [xlen-1:0] addr_mie         = 32'h0000_0004;
    localparam logic [xlen-1:0] addr_mip         = 32'h0000_0008;
    localparam logic [xlen-1:0] addr_mtvec       = 32'h0000_000C;
    localparam logic [xlen-1:0] addr_mtimecmp_lo = 32'h0000_0010;
    localparam logic [xlen-1:0] addr_mtimecmp_hi = 32'h0000_0014;

    // Bit positions in mie and mip.
    localparam int bit_msi = 3;
    localparam int bit_mti = 7;
    localparam int bit_mei = 11;

    // Global enable in mstatus.
    localparam int bit_mstatus_mie = 3;

    // Interrupt cause codes.
    localparam logic [cause_w-1:0] cause_msi = 4'd3;
    localparam logic [cause_w-1:0] cause_mti = 4'd7;
    localparam logic [cause_w-1:0] cause_mei = 4'd11;

    // mtvec mode field.
    localparam logic [mtvec_mode_w-1:0] mtvec_direct   = 2'd0;
    localparam logic [mtvec_mode_w-1:0] mtvec_vectored = 2'd1;

endpackage

//--- hdl/csr_ctrl_if.sv
`timescale 1ns/1ps

interface csr_ctrl_if import irq_pkg::*; ();

    logic                    global_ie;
    logic                    mie_msi;
    logic                    mie_mti;
    logic                    mie_mei;
    logic [mtvec_base_w-1:0] mtvec_base;
    logic [mtvec_mode_w-1:0] mtvec_mode;
    logic [mtime_w-1:0]      mtimecmp;
    // Pulse from a bus write of 1 to mip.MSIP.
    logic                    soft_set;

    modport bank (
        output global_ie, mie_msi, mie_mti, mie_mei,
        output mtvec_base, mtvec_mode, mtimecmp, soft_set
    );

    modport user (
        input global_ie, mie_msi, mie_mti, mie_mei,
        input mtvec_base, mtvec_mode, mtimecmp, soft_set
    );

endinterface

//--- hdl/irq_csr_bank.sv
`timescale 1ns/1ps

module irq_csr_bank import irq_pkg::*; (
    input  logic            CLK,
    input  logic            rst_n,
    input  logic            ren,
    input  logic            wen,
    input  logic [be_w-1:0] byte_en,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wdata,
    output logic            busy,
    output logic            error,
    output logic [xlen-1:0] rdata,
    input  logic            pend_msi,
    input  logic            pend_mti,
    input  logic            pend_mei,
    csr_ctrl_if.bank        ctrl
);

    logic                    phase_q;
    logic                    first;
    logic                    hit;
    logic                    err_q;
    logic [xlen-1:0]         cur_word;
    logic [xlen-1:0]         new_word;
    logic [xlen-1:0]         rdata_q;
    logic                    global_ie_q;
    logic                    mie_msi_q;
    logic                    mie_mti_q;
    logic                    mie_mei_q;
    logic [mtvec_base_w-1:0] mtvec_base_q;
    logic [mtvec_mode_w-1:0] mtvec_mode_q;
    logic [mtime_w-1:0]      mtimecmp_q;

    function automatic logic [xlen-1:0] merge_bytes(
        input logic [xlen-1:0] old_word,
        input logic [xlen-1:0] upd_word,
        input logic [be_w-1:0] sel
    );
        logic [xlen-1:0] result;
        result = old_word;
        for (int i = 0; i < be_w; i++) begin
            if (sel[i]) begin
                result[i*8 +: 8] = upd_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    // First cycle of an access, busy is high.
    assign first = (ren | wen) & ~phase_q;
    assign busy  = first;
    assign error = phase_q & err_q;
    assign rdata = rdata_q;

    always_comb begin
        cur_word = '0;
        hit      = 1'b1;
        case (addr)
            addr_mstatus: cur_word[bit_mstatus_mie] = global_ie_q;
            addr_mie: begin
                cur_word[bit_msi] = mie_msi_q;
                cur_word[bit_mti] = mie_mti_q;
                cur_word[bit_mei] = mie_mei_q;
            end
            addr_mip: begin
                cur_word[bit_msi] = pend_msi;
                cur_word[bit_mti] = pend_mti;
                cur_word[bit_mei] = pend_mei;
            end
            addr_mtvec:       cur_word = {mtvec_base_q, mtvec_mode_q};
            addr_mtimecmp_lo: cur_word = mtimecmp_q[xlen-1:0];
            addr_mtimecmp_hi: cur_word = mtimecmp_q[mtime_w-1:xlen];
            default:          hit = 1'b0;
        endcase
    end

    assign new_word = merge_bytes(cur_word, wdata, byte_en);

    // Only the MSIP byte lane counts.
    assign ctrl.soft_set = first & wen & (addr == addr_mip)
                         & byte_en[bit_msi / 8] & wdata[bit_msi];

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            phase_q      <= 1'b0;
            err_q        <= 1'b0;
            global_ie_q  <= 1'b0;
            mie_msi_q    <= 1'b0;
            mie_mti_q    <= 1'b0;
            mie_mei_q    <= 1'b0;
            mtvec_base_q <= '0;
            mtvec_mode_q <= mtvec_direct;
            mtimecmp_q   <= '1;
        end else begin
            phase_q <= first;
            if (first) begin
                err_q <= ~hit;
            end
            if (first && wen) begin
                case (addr)
                    addr_mstatus: global_ie_q <= new_word[bit_mstatus_mie];
                    addr_mie: begin
                        mie_msi_q <= new_word[bit_msi];
                        mie_mti_q <= new_word[bit_mti];
                        mie_mei_q <= new_word[bit_mei];
                    end
                    addr_mtvec: begin
                        mtvec_base_q <= new_word[xlen-1:mtvec_mode_w];
                        // Reserved modes fall back to direct.
                        mtvec_mode_q <= (new_word[mtvec_mode_w-1:0] == mtvec_vectored)
                                      ? mtvec_vectored : mtvec_direct;
                    end
                    addr_mtimecmp_lo: mtimecmp_q[xlen-1:0]       <= new_word;
                    addr_mtimecmp_hi: mtimecmp_q[mtime_w-1:xlen] <= new_word;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (first) begin
            rdata_q <= cur_word;
        end
    end

    assign ctrl.global_ie  = global_ie_q;
    assign ctrl.mie_msi    = mie_msi_q;
    assign ctrl.mie_mti    = mie_mti_q;
    assign ctrl.mie_mei    = mie_mei_q;
    assign ctrl.mtvec_base = mtvec_base_q;
    assign ctrl.mtvec_mode = mtvec_mode_q;
    assign ctrl.mtimecmp   = mtimecmp_q;

endmodule

//--- hdl/irq_pending.sv
`timescale 1ns/1ps

module irq_pending import irq_pkg::*; (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic [mtime_w-1:0] mtime,
    input  logic               ext_int,
    input  logic               ext_int_clear,
    input  logic               soft_int,
    input  logic               soft_int_clear,
    input  logic               timer_int,
    input  logic               timer_int_clear,
    csr_ctrl_if.user           ctrl,
    output logic               pend_msi,
    output logic               pend_mti,
    output logic               pend_mei
);

    logic pend_mei_q;
    logic pend_msi_q;
    logic timer_q;
    logic cmp_q;

    // Sticky bits, clear wins over set.
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pend_mei_q <= 1'b0;
            pend_msi_q <= 1'b0;
            timer_q    <= 1'b0;
            cmp_q      <= 1'b0;
        end else begin
            if (ext_int_clear) begin
                pend_mei_q <= 1'b0;
            end else if (ext_int) begin
                pend_mei_q <= 1'b1;
            end

            if (soft_int_clear) begin
                pend_msi_q <= 1'b0;
            end else if (soft_int || ctrl.soft_set) begin
                pend_msi_q <= 1'b1;
            end

            if (timer_int_clear) begin
                timer_q <= 1'b0;
            end else if (timer_int) begin
                timer_q <= 1'b1;
            end

            // Level compare, cleared by moving mtimecmp.
            cmp_q <= (mtime >= ctrl.mtimecmp);
        end
    end

    assign pend_mei = pend_mei_q;
    assign pend_msi = pend_msi_q;
    assign pend_mti = timer_q | cmp_q;

endmodule

//--- hdl/trap_select.sv
`timescale 1ns/1ps

module trap_select import irq_pkg::*; (
    input  logic               pend_msi,
    input  logic               pend_mti,
    input  logic               pend_mei,
    csr_ctrl_if.user           ctrl,
    output logic               irq_req,
    output logic [cause_w-1:0] irq_cause,
    output logic [xlen-1:0]    irq_vector
);

    logic            take_msi;
    logic            take_mti;
    logic            take_mei;
    logic [xlen-1:0] base_addr;

    assign take_msi = pend_msi & ctrl.mie_msi & ctrl.global_ie;
    assign take_mti = pend_mti & ctrl.mie_mti & ctrl.global_ie;
    assign take_mei = pend_mei & ctrl.mie_mei & ctrl.global_ie;

    assign irq_req = take_msi | take_mti | take_mei;

    // External, then software, then timer.
    always_comb begin
        if (take_mei) begin
            irq_cause = cause_mei;
        end else if (take_msi) begin
            irq_cause = cause_msi;
        end else if (take_mti) begin
            irq_cause = cause_mti;
        end else begin
            irq_cause = '0;
        end
    end

    assign base_addr = {ctrl.mtvec_base, {mtvec_mode_w{1'b0}}};

    // Vectored entries are one word apart.
    assign irq_vector = (ctrl.mtvec_mode == mtvec_vectored)
                      ? base_addr + xlen'({irq_cause, 2'b00})
                      : base_addr;

endmodule

//--- hdl/core_irq_unit.sv
`timescale 1ns/1ps

module core_irq_unit import irq_pkg::*; (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic [mtime_w-1:0] mtime,
    input  logic               ext_int,
    input  logic               ext_int_clear,
    input  logic               soft_int,
    input  logic               soft_int_clear,
    input  logic               timer_int,
    input  logic               timer_int_clear,
    input  logic               ren,
    input  logic               wen,
    input  logic [be_w-1:0]    byte_en,
    input  logic [xlen-1:0]    addr,
    input  logic [xlen-1:0]    wdata,
    output logic               busy,
    output logic               error,
    output logic [xlen-1:0]    rdata,
    output logic               irq_req,
    output logic [cause_w-1:0] irq_cause,
    output logic [xlen-1:0]    irq_vector
);

    logic pend_msi;
    logic pend_mti;
    logic pend_mei;

    csr_ctrl_if ctrl_if ();

    irq_csr_bank u_csr_bank (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .ren      (ren),
        .wen      (wen),
        .byte_en  (byte_en),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .error    (error),
        .rdata    (rdata),
        .pend_msi (pend_msi),
        .pend_mti (pend_mti),
        .pend_mei (pend_mei),
        .ctrl     (ctrl_if.bank)
    );

    irq_pending u_pending (
        .CLK             (CLK),
        .rst_n           (rst_n),
        .mtime           (mtime),
        .ext_int         (ext_int),
        .ext_int_clear   (ext_int_clear),
        .soft_int        (soft_int),
        .soft_int_clear  (soft_int_clear),
        .timer_int       (timer_int),
        .timer_int_clear (timer_int_clear),
        .ctrl            (ctrl_if.user),
        .pend_msi        (pend_msi),
        .pend_mti        (pend_mti),
        .pend_mei        (pend_mei)
    );

    trap_select u_trap_select (
        .pend_msi   (pend_msi),
        .pend_mti   (pend_mti),
        .pend_mei   (pend_mei),
        .ctrl       (ctrl_if.user),
        .irq_req    (irq_req),
        .irq_cause  (irq_cause),
        .irq_vector (irq_vector)
    );

endmodule

//--- tb/core_irq_unit_asserts.sv
`timescale 1ns/1ps

module core_irq_unit_asserts (
    input logic CLK,
    input logic rst_n,
    input logic busy,
    input logic error,
    input logic irq_req,
    input logic global_ie
);

    int fail_count = 0;

    // Every access completes in the cycle after busy.
    busy_one_cycle: assert property (@(posedge CLK) disable iff (!rst_n) busy |=> !busy)
        else begin
            fail_count++;
            $error("busy stayed high for two cycles");
        end

    error_not_busy: assert property (@(posedge CLK) disable iff (!rst_n) error |-> !busy)
        else begin
            fail_count++;
            $error("error raised while busy was high");
        end

    req_needs_ie: assert property (@(posedge CLK) disable iff (!rst_n) !global_ie |-> !irq_req)
        else begin
            fail_count++;
            $error("irq_req raised with global interrupt enable low");
        end

endmodule

bind core_irq_unit core_irq_unit_asserts u_asserts (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .busy      (busy),
    .error     (error),
    .irq_req   (irq_req),
    .global_ie (ctrl_if.global_ie)
);

//--- tb/core_irq_unit_tb.sv
`timescale 1ns/1ps

module core_irq_unit_tb import irq_pkg::*; ();

    typedef enum logic [1:0] {op_none, op_read, op_write} op_t;

    // Line bits in order ext, ext_clr, soft, soft_clr, timer, timer_clr.
    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
        logic [5:0]  lines;
        logic [63:0] mtime;
        logic [31:0] exp_rdata;
        logic        exp_err;
        logic        exp_req;
        logic [3:0]  exp_cause;
        logic [31:0] exp_vec;
    } entry_t;

    logic        CLK;
    logic        rst_n;
    logic [63:0] mtime;
    logic        ext_int;
    logic        ext_int_clear;
    logic        soft_int;
    logic        soft_int_clear;
    logic        timer_int;
    logic        timer_int_clear;
    logic        ren;
    logic        wen;
    logic [3:0]  byte_en;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        busy;
    logic        error;
    logic [31:0] rdata;
    logic        irq_req;
    logic [3:0]  irq_cause;
    logic [31:0] irq_vector;

    entry_t      tbl[$];
    bit          tbl_ready = 1'b0;
    logic [31:0] rng = 32'h6447_142e;
    logic [31:0] m_mtvec;
    logic [63:0] cur_mtime;
    int          errors;
    int          checks;

    core_irq_unit u_core_irq_unit (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Byte-enabled update of mtvec; reserved modes become direct.
    function automatic logic [31:0] mtvec_after(input logic [31:0] old,
                                                input logic [31:0] d,
                                                input logic [3:0] be);
        logic [31:0] v;
        v = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                v[i*8 +: 8] = d[i*8 +: 8];
            end
        end
        if (v[1:0] != 2'd1) begin
            v[1:0] = 2'd0;
        end
        return v;
    endfunction

    function automatic logic [31:0] vector_of(input logic [31:0] tvec, input logic [3:0] cause);
        logic [31:0] base;
        base = {tvec[31:2], 2'b00};
        return (tvec[1:0] == 2'd1) ? base + {26'd0, cause, 2'b00} : base;
    endfunction

    task automatic add_entry(input op_t op, input logic [31:0] a, input logic [31:0] d,
                             input logic [3:0] be, input logic [5:0] lines,
                             input logic [31:0] exp_rdata, input logic exp_err,
                             input logic exp_req, input logic [3:0] exp_cause);
        entry_t e;
        if (op == op_write && a == addr_mtvec) begin
            m_mtvec = mtvec_after(m_mtvec, d, be);
        end
        e = '{op, a, d, be, lines, cur_mtime, exp_rdata, exp_err, exp_req, exp_cause,
              vector_of(m_mtvec, exp_cause)};
        tbl.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] r;
        m_mtvec   = '0;
        cur_mtime = '0;
        add_entry(op_read, addr_mie, 32'h0, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_read, addr_mip, 32'h0, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_read, addr_mtvec, 32'h0, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_read, addr_mtimecmp_lo, 32'h0, 4'hf, 6'b0, '1, 1'b0, 1'b0, 4'd0);
        add_entry(op_read, addr_mtimecmp_hi, 32'h0, 4'hf, 6'b0, '1, 1'b0, 1'b0, 4'd0);
        // Partial writes and unmapped accesses.
        add_entry(op_write, addr_mtvec, 32'h8000_0101, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_write, addr_mtvec, next_rand(), 4'b0010, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_read, addr_mtvec, 32'h0, 4'hf, 6'b0, m_mtvec, 1'b0, 1'b0, 4'd0);
        add_entry(op_write, 32'h18, next_rand(), 4'hf, 6'b0, 32'h0, 1'b1, 1'b0, 4'd0);
        add_entry(op_read, 32'h40, 32'h0, 4'hf, 6'b0, 32'h0, 1'b1, 1'b0, 4'd0);
        add_entry(op_read, addr_mtvec, 32'h0, 4'hf, 6'b0, m_mtvec, 1'b0, 1'b0, 4'd0);
        // Priority between external and software.
        add_entry(op_write, addr_mstatus, 32'h8, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_write, addr_mie, 32'h888, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_none, 32'h0, 32'h0, 4'h0, 6'b101000, 32'h0, 1'b0, 1'b1, 4'd11);
        add_entry(op_none, 32'h0, 32'h0, 4'h0, 6'b010000, 32'h0, 1'b0, 1'b1, 4'd3);
        add_entry(op_read, addr_mip, 32'h0, 4'hf, 6'b0, 32'h8, 1'b0, 1'b1, 4'd3);
        // Direct, then vectored.
        add_entry(op_write, addr_mtvec, 32'h2000, 4'hf, 6'b0, 32'h0, 1'b0, 1'b1, 4'd3);
        add_entry(op_write, addr_mtvec, 32'h2001, 4'hf, 6'b0, 32'h0, 1'b0, 1'b1, 4'd3);
        // Masking keeps the bit pending.
        add_entry(op_write, addr_mie, 32'h880, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_read, addr_mip, 32'h0, 4'hf, 6'b0, 32'h8, 1'b0, 1'b0, 4'd0);
        add_entry(op_write, addr_mie, 32'h888, 4'hf, 6'b0, 32'h0, 1'b0, 1'b1, 4'd3);
        add_entry(op_write, addr_mstatus, 32'h0, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_read, addr_mip, 32'h0, 4'hf, 6'b0, 32'h8, 1'b0, 1'b0, 4'd0);
        add_entry(op_write, addr_mstatus, 32'h8, 4'hf, 6'b0, 32'h0, 1'b0, 1'b1, 4'd3);
        add_entry(op_none, 32'h0, 32'h0, 4'h0, 6'b000100, 32'h0, 1'b0, 1'b0, 4'd0);
        // Timer compare against a random mtimecmp.
        r = next_rand() | 32'h0000_0100;
        add_entry(op_write, addr_mtimecmp_lo, r, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_write, addr_mtimecmp_hi, 32'h0, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_read, addr_mtimecmp_lo, 32'h0, 4'hf, 6'b0, r, 1'b0, 1'b0, 4'd0);
        cur_mtime = {32'd0, r} + 64'd5;
        add_entry(op_read, addr_mip, 32'h0, 4'hf, 6'b0, 32'h0, 1'b0, 1'b1, 4'd7);
        add_entry(op_read, addr_mip, 32'h0, 4'hf, 6'b0, 32'h80, 1'b0, 1'b1, 4'd7);
        add_entry(op_write, addr_mtimecmp_hi, 32'h1, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_read, addr_mip, 32'h0, 4'hf, 6'b0, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_none, 32'h0, 32'h0, 4'h0, 6'b000010, 32'h0, 1'b0, 1'b1, 4'd7);
        add_entry(op_none, 32'h0, 32'h0, 4'h0, 6'b000001, 32'h0, 1'b0, 1'b0, 4'd0);
        add_entry(op_write, addr_mip, 32'h8, 4'hf, 6'b0, 32'h0, 1'b0, 1'b1, 4'd3);
        add_entry(op_none, 32'h0, 32'h0, 4'h0, 6'b000100, 32'h0, 1'b0, 1'b0, 4'd0);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apply(input entry_t e, input int idx);
        @(posedge CLK);
        #1;
        {ext_int, ext_int_clear, soft_int, soft_int_clear, timer_int, timer_int_clear} = e.lines;
        mtime   = e.mtime;
        ren     = (e.op == op_read);
        wen     = (e.op == op_write);
        addr    = e.addr;
        wdata   = e.data;
        byte_en = e.be;
        @(negedge CLK);
        check(32'(busy), 32'(e.op != op_none), $sformatf("entry %0d busy", idx));
        // Bus result is valid in the cycle busy is low.
        while (busy) begin
            @(negedge CLK);
        end
        if (e.op != op_none) begin
            check(32'(error), 32'(e.exp_err), $sformatf("entry %0d error", idx));
            if (e.op == op_read && !e.exp_err) begin
                check(rdata, e.exp_rdata, $sformatf("entry %0d rdata", idx));
            end
        end
        @(posedge CLK);
        #1;
        {ext_int, ext_int_clear, soft_int, soft_int_clear, timer_int, timer_int_clear} = '0;
        ren = 1'b0;
        wen = 1'b0;
        @(negedge CLK);
        check(32'(irq_req), 32'(e.exp_req), $sformatf("entry %0d irq_req", idx));
        if (e.exp_req) begin
            check(32'(irq_cause), 32'(e.exp_cause), $sformatf("entry %0d irq_cause", idx));
            check(irq_vector, e.exp_vec, $sformatf("entry %0d irq_vector", idx));
        end
    endtask

    initial begin
        int assert_fails;
        {ext_int, ext_int_clear, soft_int, soft_int_clear, timer_int, timer_int_clear} = '0;
        rst_n   = 1'b0;
        mtime   = '0;
        ren     = 1'b0;
        wen     = 1'b0;
        byte_en = '0;
        addr    = '0;
        wdata   = '0;
        errors  = 0;
        checks  = 0;
        build_table();
        tbl_ready = 1'b1;
        repeat (4) @(posedge CLK);
        #1;
        rst_n = 1'b1;
        foreach (tbl[i]) begin
            apply(tbl[i], i);
        end
        assert_fails = u_core_irq_unit.u_asserts.fail_count;
        $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Ten cycles per table entry plus reset.
    initial begin
        longint limit_ns;
        wait (tbl_ready);
        limit_ns = (longint'(tbl.size()) * 10 + 4) * 100;
        #(limit_ns);
        $display("Watchdog timeout: the table did not complete within %0d ns", limit_ns);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- project.f
hdl/irq_pkg.sv
hdl/csr_ctrl_if.sv
hdl/irq_csr_bank.sv
hdl/irq_pending.sv
hdl/trap_select.sv
hdl/core_irq_unit.sv
tb/core_irq_unit_asserts.sv
tb/core_irq_unit_tb.sv

//--- Makefile
TOP := core_irq_unit_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
